// ==== source/soc_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared address map, register offsets and bus types of the peripheral side.
// Import it inside each module body that needs one of these names.
////////////////////////////////////////////////////////////////////////////
package soc_pkg;

  // bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;
  typedef logic [15:0] baud_div_t;
  typedef logic [7:0] uart_byte_t;

  // I/O window, both ends inclusive
  localparam addr_t IO_BASE = 32'h1000_0000;
  localparam addr_t IO_END = 32'h1200_0000;

  // uart ports, one window of UART_STRIDE bytes each
  localparam addr_t UART_BASE = 32'h1000_0000;
  localparam addr_t UART_STRIDE = 32'h0000_0100;
  // write is TX, read is RX
  localparam addr_t UART_DATA_OFS = 32'h0000_0000;
  localparam addr_t UART_LSR_OFS = 32'h0000_0014;

  // system register block
  localparam addr_t SYS_BASE = 32'h1100_0000;
  localparam addr_t DIV_OFS = 32'h0000_0000;
  localparam addr_t FREQ_OFS = 32'h0000_0004;
  localparam addr_t MEMSIZE_OFS = 32'h0000_0008;
  localparam addr_t REBOOT_ADDR = 32'h1100_0100;
  localparam logic [15:0] REBOOT_MAGIC = 16'h7777;

  // line status bits
  localparam int LSR_DR_BIT = 0;
  localparam int LSR_THRE_BIT = 5;
  localparam int LSR_TEMT_BIT = 6;

  // RX reads this while nothing is waiting
  localparam data_t RX_EMPTY_WORD = 32'hFFFF_FFFF;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_t;

endpackage

// ==== source/uart_tx.sv ====
////////////////////////////////////////////////////////////////////////////
// 8N1 serial transmitter with a one-byte holding register in front of the
// shifter. Push a byte with valid_i while ready_o is high.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_tx (
  input  logic                clk,
  input  logic                resetn,
  input  logic                valid_i,
  input  soc_pkg::uart_byte_t data_i,
  input  soc_pkg::baud_div_t  baud_div_i,
  output logic                tx_o,
  output logic                ready_o,
  output logic                busy_o
);

  import soc_pkg::*;

  uart_tx_state_t state_q;
  baud_div_t cnt_q;
  logic [2:0] bit_q;
  logic hold_full_q;
  logic tx_q;
  uart_byte_t hold_q;
  uart_byte_t shift_q;
  logic bit_end;
  logic load;

  assign bit_end = (cnt_q == baud_div_i - 16'd1);
  // holding register moves into the shifter only from idle
  assign load = (state_q == TX_IDLE) && hold_full_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= TX_IDLE;
      cnt_q <= '0;
      bit_q <= '0;
      hold_full_q <= 1'b0;
      tx_q <= 1'b1;
    end else begin
      cnt_q <= cnt_q + 16'd1;
      if (valid_i && !hold_full_q) begin
        hold_full_q <= 1'b1;
      end
      case (state_q)
        TX_IDLE: begin
          cnt_q <= '0;
          if (hold_full_q) begin
            hold_full_q <= 1'b0;
            tx_q <= 1'b0;
            state_q <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            cnt_q <= '0;
            bit_q <= '0;
            tx_q <= shift_q[0];
            state_q <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            if (bit_q == 3'd7) begin
              tx_q <= 1'b1;
              state_q <= TX_STOP;
            end else begin
              bit_q <= bit_q + 3'd1;
              tx_q <= shift_q[bit_q + 3'd1];
            end
          end
        end
        default: begin
          // stop bit, line already high
          if (bit_end) begin
            cnt_q <= '0;
            state_q <= TX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && !hold_full_q) begin
      hold_q <= data_i;
    end
    if (load) begin
      shift_q <= hold_q;
    end
  end

  assign tx_o = tx_q;
  assign ready_o = !hold_full_q;
  assign busy_o = hold_full_q || (state_q != TX_IDLE);

endmodule

// ==== source/uart_rx.sv ====
////////////////////////////////////////////////////////////////////////////
// 8N1 serial receiver with a one-byte buffer. data_o holds the byte
// zero-extended until read_i, otherwise it reads all ones.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_rx (
  input  logic               clk,
  input  logic               resetn,
  input  logic               rx_i,
  input  soc_pkg::baud_div_t baud_div_i,
  input  logic               read_i,
  output soc_pkg::data_t     data_o
);

  import soc_pkg::*;

  uart_rx_state_t state_q;
  baud_div_t cnt_q;
  logic [2:0] bit_q;
  logic rx_meta_q;
  logic rx_s_q;
  logic full_q;
  uart_byte_t shift_q;
  uart_byte_t buf_q;
  logic half_end;
  logic bit_end;
  logic sample_bit;
  logic stop_ok;

  assign half_end = (cnt_q == (baud_div_i >> 1) - 16'd1);
  assign bit_end = (cnt_q == baud_div_i - 16'd1);
  assign sample_bit = (state_q == RX_DATA) && bit_end;
  // a low stop bit drops the byte
  assign stop_ok = (state_q == RX_STOP) && bit_end && rx_s_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      rx_meta_q <= 1'b1;
      rx_s_q <= 1'b1;
      state_q <= RX_IDLE;
      cnt_q <= '0;
      bit_q <= '0;
      full_q <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_s_q <= rx_meta_q;
      cnt_q <= cnt_q + 16'd1;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_s_q) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // middle of the start bit, reject glitches
          if (half_end) begin
            cnt_q <= '0;
            bit_q <= '0;
            state_q <= rx_s_q ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state_q <= RX_IDLE;
          end
        end
      endcase

      // new byte wins over a read in the same cycle
      if (stop_ok) begin
        full_q <= 1'b1;
      end else if (read_i) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample_bit) begin
      shift_q <= {rx_s_q, shift_q[7:1]};
    end
    if (stop_ok) begin
      buf_q <= shift_q;
    end
  end

  assign data_o = full_q ? data_t'(buf_q) : RX_EMPTY_WORD;

endmodule

// ==== source/uart_port.sv ====
////////////////////////////////////////////////////////////////////////////
// Bus side of one UART port: TX holding write, RX read and line status.
// A TX write waits until the transmitter can take the byte.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module uart_port (
  input  logic               clk,
  input  logic               resetn,
  input  logic               sel_i,
  input  soc_pkg::addr_t     addr_i,
  input  soc_pkg::strb_t     wstrb_i,
  input  soc_pkg::data_t     wdata_i,
  input  soc_pkg::baud_div_t baud_div_i,
  output logic               ready_o,
  output soc_pkg::data_t     rdata_o,
  output logic               irq_o,
  output logic               tx_o,
  input  logic               rx_i
);

  import soc_pkg::*;

  localparam addr_t OFS_MASK = UART_STRIDE - 32'd1;

  logic wr;
  logic is_data;
  logic is_lsr;
  logic tx_hit;
  logic tx_accept;
  logic other_take;
  logic rx_read;
  logic tx_ready;
  logic tx_busy;
  logic data_ready;
  logic ready_q;
  logic tx_seen_q;
  logic thre_q;
  data_t rx_data;
  data_t rdata_q;
  uart_byte_t lsr;

  assign wr = |wstrb_i;
  assign is_data = ((addr_i & OFS_MASK) == UART_DATA_OFS);
  assign is_lsr = ((addr_i & OFS_MASK) == UART_LSR_OFS);

  // TX write, accepted once per request
  assign tx_hit = sel_i && wr && is_data;
  assign tx_accept = tx_hit && !tx_seen_q && tx_ready;

  // every other access answers after one cycle
  assign other_take = sel_i && !(wr && is_data) && !ready_q;
  assign rx_read = other_take && is_data;

  assign data_ready = (rx_data != RX_EMPTY_WORD);

  always_comb begin
    lsr = '0;
    lsr[LSR_DR_BIT] = data_ready;
    lsr[LSR_THRE_BIT] = thre_q;
    lsr[LSR_TEMT_BIT] = !tx_busy;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      tx_seen_q <= 1'b0;
      thre_q <= 1'b1;
    end else begin
      ready_q <= tx_accept || other_take;
      // held until the request goes away
      if (!tx_hit) begin
        tx_seen_q <= 1'b0;
      end else if (tx_accept) begin
        tx_seen_q <= 1'b1;
      end
      if (tx_accept) begin
        thre_q <= 1'b0;
      end else if (tx_ready) begin
        thre_q <= 1'b1;
      end
    end
  end

  // RX is captured before the read clears the buffer
  always_ff @(posedge clk) begin
    if (tx_accept) begin
      rdata_q <= '0;
    end else if (other_take) begin
      if (is_lsr) begin
        rdata_q <= {16'h0000, lsr, 8'h00};
      end else if (is_data) begin
        rdata_q <= rx_data;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  uart_tx u_tx (
    .clk       (clk),
    .resetn    (resetn),
    .valid_i   (tx_accept),
    .data_i    (wdata_i[7:0]),
    .baud_div_i(baud_div_i),
    .tx_o      (tx_o),
    .ready_o   (tx_ready),
    .busy_o    (tx_busy)
  );

  uart_rx u_rx (
    .clk       (clk),
    .resetn    (resetn),
    .rx_i      (rx_i),
    .baud_div_i(baud_div_i),
    .read_i    (rx_read),
    .data_o    (rx_data)
  );

  assign ready_o = ready_q;
  assign rdata_o = ready_q ? rdata_q : '0;
  assign irq_o = data_ready || tx_busy;

endmodule

// ==== source/sys_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// System registers: divider, clock frequency, memory size and the reboot
// command. Any offset in the block answers after one cycle.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module sys_regs #(
  parameter soc_pkg::data_t SYSTEM_CLK = 32'd50_000_000,
  parameter soc_pkg::data_t MEM_SIZE = 32'h0100_0000
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic               sel_i,
  input  soc_pkg::addr_t     addr_i,
  input  soc_pkg::strb_t     wstrb_i,
  input  soc_pkg::data_t     wdata_i,
  output logic               ready_o,
  output soc_pkg::data_t     rdata_o,
  output soc_pkg::baud_div_t baud_div_o,
  output logic               reboot_o
);

  import soc_pkg::*;

  logic take;
  logic wr;
  logic is_div;
  logic is_reboot;
  logic ready_q;
  logic reboot_hit_q;
  logic reboot_q;
  data_t div_q;
  data_t rd_word;
  data_t rdata_q;

  assign take = sel_i && !ready_q;
  assign wr = |wstrb_i;
  assign is_div = (addr_i == SYS_BASE + DIV_OFS);
  assign is_reboot = wr && (addr_i == REBOOT_ADDR) && (wdata_i[15:0] == REBOOT_MAGIC);

  always_comb begin
    rd_word = '0;
    if (is_div) begin
      rd_word = div_q;
    end else if (addr_i == SYS_BASE + FREQ_OFS) begin
      rd_word = SYSTEM_CLK;
    end else if (addr_i == SYS_BASE + MEMSIZE_OFS) begin
      rd_word = MEM_SIZE;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      reboot_hit_q <= 1'b0;
      reboot_q <= 1'b0;
      div_q <= '0;
    end else begin
      ready_q <= take;
      // match lines up with ready, pulse comes one cycle later
      reboot_hit_q <= take && is_reboot;
      reboot_q <= reboot_hit_q;
      if (take && wr && is_div) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb_i[b]) begin
            div_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rdata_q <= rd_word;
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = ready_q ? rdata_q : '0;
  // upper half is kept for software only
  assign baud_div_o = div_q[15:0];
  assign reboot_o = reboot_q;

endmodule

// ==== source/boot_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// On-chip word RAM with byte write strobes and a registered read port.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module boot_ram #(
  parameter int BRAM_WORDS = 256
) (
  input  logic           clk,
  input  logic           resetn,
  input  logic           sel_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::strb_t wstrb_i,
  input  soc_pkg::data_t wdata_i,
  output logic           ready_o,
  output soc_pkg::data_t rdata_o
);

  import soc_pkg::*;

  localparam int AW = $clog2(BRAM_WORDS);

  data_t mem [BRAM_WORDS];
  data_t rdata_q;
  logic ready_q;
  logic take;
  logic [AW-1:0] idx;

  assign take = sel_i && !ready_q;
  // word index, byte lane bits dropped
  assign idx = addr_i[2 +: AW];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_q <= mem[idx];
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = ready_q ? rdata_q : '0;

endmodule

// ==== source/soc_bus.sv ====
////////////////////////////////////////////////////////////////////////////
// Peripheral side of the SoC. Decodes one bus request at a time into RAM,
// system registers and UART ports, and answers faults and unmapped I/O.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module soc_bus #(
  parameter int NUM_UARTS = 2,
  parameter int BRAM_WORDS = 256,
  parameter soc_pkg::data_t SYSTEM_CLK = 32'd50_000_000,
  parameter soc_pkg::data_t MEM_SIZE = 32'h0100_0000
) (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 mem_valid_i,
  input  soc_pkg::addr_t       mem_addr_i,
  input  soc_pkg::strb_t       mem_wstrb_i,
  input  soc_pkg::data_t       mem_wdata_i,
  output logic                 mem_ready_o,
  output soc_pkg::data_t       mem_rdata_o,
  output logic                 access_fault_o,
  output logic                 reboot_o,
  output logic                 uart_irq_o,
  output logic [NUM_UARTS-1:0] uart_tx_o,
  input  logic [NUM_UARTS-1:0] uart_rx_i
);

  import soc_pkg::*;

  localparam addr_t RAM_BYTES = addr_t'(BRAM_WORDS * 4);
  // 4 KB block for the system registers
  localparam addr_t SYS_MASK = 32'h0000_0FFF;

  logic ram_hit;
  logic in_io;
  logic sys_hit;
  logic io_unmatched;
  logic io_take;
  logic fault_take;
  logic io_ready_q;
  logic fault_q;
  logic ram_ready;
  logic sys_ready;
  data_t ram_rdata;
  data_t sys_rdata;
  data_t uart_rdata;
  baud_div_t baud_div;
  logic [NUM_UARTS-1:0] port_hit;
  logic [NUM_UARTS-1:0] port_ready;
  logic [NUM_UARTS-1:0] port_irq;
  data_t port_rdata [NUM_UARTS];

  ////////////////////////////////////////////////////////////////////////////
  // region decode

  assign ram_hit = (mem_addr_i < RAM_BYTES);
  assign in_io = (mem_addr_i >= IO_BASE) && (mem_addr_i <= IO_END);
  assign sys_hit = ((mem_addr_i & ~SYS_MASK) == SYS_BASE);
  assign io_unmatched = in_io && !sys_hit && !(|port_hit);

  assign io_take = mem_valid_i && io_unmatched && !io_ready_q;
  assign fault_take = mem_valid_i && !ram_hit && !in_io && !fault_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      io_ready_q <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      io_ready_q <= io_take;
      fault_q <= fault_take;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // units

  boot_ram #(
    .BRAM_WORDS(BRAM_WORDS)
  ) u_ram (
    .clk    (clk),
    .resetn (resetn),
    .sel_i  (mem_valid_i && ram_hit),
    .addr_i (mem_addr_i),
    .wstrb_i(mem_wstrb_i),
    .wdata_i(mem_wdata_i),
    .ready_o(ram_ready),
    .rdata_o(ram_rdata)
  );

  sys_regs #(
    .SYSTEM_CLK(SYSTEM_CLK),
    .MEM_SIZE  (MEM_SIZE)
  ) u_sys (
    .clk       (clk),
    .resetn    (resetn),
    .sel_i     (mem_valid_i && sys_hit),
    .addr_i    (mem_addr_i),
    .wstrb_i   (mem_wstrb_i),
    .wdata_i   (mem_wdata_i),
    .ready_o   (sys_ready),
    .rdata_o   (sys_rdata),
    .baud_div_o(baud_div),
    .reboot_o  (reboot_o)
  );

  for (genvar i = 0; i < NUM_UARTS; i++) begin : g_uart
    localparam addr_t PORT_BASE = UART_BASE + addr_t'(i) * UART_STRIDE;

    assign port_hit[i] = ((mem_addr_i & ~(UART_STRIDE - 32'd1)) == PORT_BASE);

    uart_port u_port (
      .clk       (clk),
      .resetn    (resetn),
      .sel_i     (mem_valid_i && port_hit[i]),
      .addr_i    (mem_addr_i),
      .wstrb_i   (mem_wstrb_i),
      .wdata_i   (mem_wdata_i),
      .baud_div_i(baud_div),
      .ready_o   (port_ready[i]),
      .rdata_o   (port_rdata[i]),
      .irq_o     (port_irq[i]),
      .tx_o      (uart_tx_o[i]),
      .rx_i      (uart_rx_i[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // response, every unit drives zero outside its ready cycle

  always_comb begin
    uart_rdata = '0;
    for (int i = 0; i < NUM_UARTS; i++) begin
      uart_rdata = uart_rdata | port_rdata[i];
    end
  end

  assign mem_ready_o = ram_ready || sys_ready || (|port_ready) || io_ready_q || fault_q;
  assign mem_rdata_o = ram_rdata | sys_rdata | uart_rdata;
  assign access_fault_o = fault_q;
  // interrupt comes from port 0 only
  assign uart_irq_o = port_irq[0];

endmodule

// ==== testbench/tb_soc.sv ====
////////////////////////////////////////////////////////////////////////////
// Random-stimulus testbench for the peripheral side of the SoC. Drives the
// bus, checks RAM, system registers, UART loopback, faults and reboot.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_soc;

  localparam int NUM_UARTS = 2;
  localparam int BRAM_WORDS = 256;
  localparam logic [31:0] SYSTEM_CLK = 32'd50_000_000;
  localparam logic [31:0] MEM_SIZE = 32'h0100_0000;
  localparam logic [31:0] RAM_BYTES = 32'd1024;
  localparam logic [31:0] IO_LO = 32'h1000_0000;
  localparam logic [31:0] IO_HI = 32'h1200_0000;
  localparam logic [31:0] UART0 = 32'h1000_0000;
  localparam logic [31:0] SYS = 32'h1100_0000;
  localparam logic [31:0] REBOOT = 32'h1100_0100;
  localparam logic [31:0] RX_EMPTY = 32'hFFFF_FFFF;
  localparam int WAIT_LIMIT = 1000;

  logic clk;
  logic resetn;
  logic mem_valid;
  logic [31:0] mem_addr;
  logic [3:0] mem_wstrb;
  logic [31:0] mem_wdata;
  logic mem_ready;
  logic [31:0] mem_rdata;
  logic access_fault;
  logic reboot;
  logic uart_irq;
  logic [NUM_UARTS-1:0] uart_tx;
  logic [NUM_UARTS-1:0] uart_rx;

  // reference model
  logic [31:0] model_ram [BRAM_WORDS];
  logic [31:0] model_div;
  logic [7:0] last_tx [NUM_UARTS];

  // last bus response
  logic [31:0] rsp_rdata;
  logic rsp_fault;
  int rsp_cycles;

  int cycle_cnt = 0;
  int ready_cycle = 0;
  int pulse_cycle = 0;
  int pulse_count = 0;
  int error_count = 0;

  soc_bus #(
    .NUM_UARTS (NUM_UARTS),
    .BRAM_WORDS(BRAM_WORDS),
    .SYSTEM_CLK(SYSTEM_CLK),
    .MEM_SIZE  (MEM_SIZE)
  ) dut0 (
    .clk           (clk),
    .resetn        (resetn),
    .mem_valid_i   (mem_valid),
    .mem_addr_i    (mem_addr),
    .mem_wstrb_i   (mem_wstrb),
    .mem_wdata_i   (mem_wdata),
    .mem_ready_o   (mem_ready),
    .mem_rdata_o   (mem_rdata),
    .access_fault_o(access_fault),
    .reboot_o      (reboot),
    .uart_irq_o    (uart_irq),
    .uart_tx_o     (uart_tx),
    .uart_rx_i     (uart_rx)
  );

  // serial loopback on every port
  assign uart_rx = uart_tx;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // sampled on the falling edge, away from register updates
  always @(negedge clk) begin
    cycle_cnt++;
    if (mem_ready) begin
      ready_cycle = cycle_cnt;
    end
    if (reboot) begin
      pulse_count++;
      pulse_cycle = cycle_cnt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic timeout_stop(input string what);
    $display("timeout while waiting for %s", what);
    $display("Some tests failed");
    $fatal(1, "wait loop ran out of cycles");
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // status byte sits in bits 15 to 8
  function automatic logic [31:0] lsr_word(input logic dr, input logic thre,
                                           input logic temt);
    return {16'h0000, 1'b0, temt, thre, 4'b0000, dr, 8'h00};
  endfunction

  // called at posedge + 1 ns, returns there too
  task automatic bus_access(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] wdata);
    int n;
    mem_valid = 1'b1;
    mem_addr = addr;
    mem_wstrb = strb;
    mem_wdata = wdata;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!mem_ready && n < WAIT_LIMIT);
    if (!mem_ready) begin
      timeout_stop("mem_ready");
    end
    rsp_rdata = mem_rdata;
    rsp_fault = access_fault;
    rsp_cycles = n;
    mem_valid = 1'b0;
    mem_wstrb = 4'h0;
    @(posedge clk);
    #1;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] wdata);
    bus_access(addr, strb, wdata);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_access(addr, 4'h0, 32'h0);
    rdata = rsp_rdata;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
    end
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] rd;
    logic [31:0] base;
    logic [3:0] strb;
    logic [7:0] idx;
    int polls;
    int pulses_before;

    void'($urandom(32'he82f));
    resetn = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wstrb = '0;
    mem_wdata = '0;
    repeat (3) begin
      @(posedge clk);
    end
    #1;
    resetn = 1'b1;

    check("reset ready", 32'd0, 32'(mem_ready));
    check("reset fault", 32'd0, 32'(access_fault));
    check("reset reboot", 32'd0, 32'(reboot));
    check("reset irq", 32'd0, 32'(uart_irq));
    check("reset tx lines", 32'd3, 32'(uart_tx));

    // uart status after reset
    for (int p = 0; p < NUM_UARTS; p++) begin
      base = UART0 + 32'(p) * 32'h100;
      bus_read(base + 32'h14, rd);
      check($sformatf("lsr after reset port %0d", p), lsr_word(1'b0, 1'b1, 1'b1), rd);
      check("lsr latency", 32'd1, 32'(rsp_cycles));
      bus_read(base, rd);
      check($sformatf("rx empty port %0d", p), RX_EMPTY, rd);
    end

    // fill the whole RAM so every later read is defined
    for (int i = 0; i < BRAM_WORDS; i++) begin
      data = $urandom;
      bus_write(32'(i) * 32'd4, 4'hF, data);
      model_ram[i] = data;
      check("ram fill latency", 32'd1, 32'(rsp_cycles));
    end
    for (int i = 0; i < 400; i++) begin
      idx = 8'($urandom);
      addr = {22'd0, idx, 2'b00};
      strb = ($urandom % 2 == 1) ? 4'($urandom) : 4'h0;
      if (strb != 4'h0) begin
        data = $urandom;
        bus_write(addr, strb, data);
        model_ram[idx] = merge_bytes(model_ram[idx], data, strb);
      end else begin
        bus_read(addr, rd);
        check($sformatf("ram read word %0d", idx), model_ram[idx], rd);
      end
      check("ram latency", 32'd1, 32'(rsp_cycles));
    end

    // system registers
    model_div = $urandom;
    bus_write(SYS, 4'hF, model_div);
    bus_read(SYS, rd);
    check("divider readback", model_div, rd);
    bus_read(SYS + 32'h4, rd);
    check("clock frequency", SYSTEM_CLK, rd);
    bus_read(SYS + 32'h8, rd);
    check("memory size", MEM_SIZE, rd);
    bus_write(SYS, 4'b0011, 32'h0000_0004);
    model_div = merge_bytes(model_div, 32'h0000_0004, 4'b0011);
    bus_read(SYS, rd);
    check("divider low half", model_div, rd);

    // uart loopback
    for (int p = 0; p < NUM_UARTS; p++) begin
      base = UART0 + 32'(p) * 32'h100;
      data = $urandom;
      last_tx[p] = data[7:0];
      bus_write(base, 4'hF, data);
      polls = 0;
      do begin
        bus_read(base + 32'h14, rd);
        polls++;
      end while (!rd[8] && polls < WAIT_LIMIT);
      if (!rd[8]) begin
        timeout_stop("received byte in line status");
      end
      if (p == 0) begin
        check("uart irq with byte waiting", 32'd1, 32'(uart_irq));
      end
      bus_read(base, rd);
      check($sformatf("rx byte port %0d", p), {24'h0, last_tx[p]}, rd);
      bus_read(base, rd);
      check($sformatf("rx after read port %0d", p), RX_EMPTY, rd);
    end

    // outside RAM and I/O window
    for (int i = 0; i < 40; i++) begin
      do begin
        addr = $urandom & 32'hFFFF_FFFC;
      end while (addr < RAM_BYTES || (addr >= IO_LO && addr <= IO_HI));
      strb = ($urandom % 2 == 1) ? 4'($urandom) : 4'h0;
      bus_access(addr, strb, $urandom);
      check("fault flag", 32'd1, 32'(rsp_fault));
      check("fault rdata", 32'd0, rsp_rdata);
      check("fault latency", 32'd1, 32'(rsp_cycles));
    end

    // unmapped holes of the I/O window
    for (int i = 0; i < 40; i++) begin
      do begin
        addr = IO_LO + (($urandom % 32'h0200_0001) & 32'hFFFF_FFFC);
      end while (addr < UART0 + 32'h200 || (addr >= SYS && addr < SYS + 32'h1000));
      strb = ($urandom % 2 == 1) ? 4'($urandom) : 4'h0;
      bus_access(addr, strb, $urandom);
      check("unmapped io fault", 32'd0, 32'(rsp_fault));
      check("unmapped io rdata", 32'd0, rsp_rdata);
      check("unmapped io latency", 32'd1, 32'(rsp_cycles));
    end

    // reboot command
    pulses_before = pulse_count;
    bus_write(REBOOT, 4'hF, {16'($urandom), 16'h7777});
    wait_cycles(4);
    check("reboot pulse count", 32'(pulses_before + 1), 32'(pulse_count));
    check("reboot pulse cycle", 32'(ready_cycle + 1), 32'(pulse_cycle));
    do begin
      data = $urandom;
    end while (data[15:0] == 16'h7777);
    pulses_before = pulse_count;
    bus_write(REBOOT, 4'hF, data);
    wait_cycles(4);
    check("no reboot without magic", 32'(pulses_before), 32'(pulse_count));

    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
source/soc_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_port.sv
source/sys_regs.sv
source/boot_ram.sv
source/soc_bus.sv
testbench/tb_soc.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_soc -f all.f -Mdir obj_dir -o tb_soc
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_soc > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation finished without failure"
exit 0
